// ==== include/tsb_settings.svh ====
`ifndef TSB_SETTINGS_SVH
`define TSB_SETTINGS_SVH

// entry count is 2**TSB_LOG_SIZE.
`define TSB_LOG_SIZE        3
`define TSB_SIZE            (1 << `TSB_LOG_SIZE)

// tile count after reset, and the largest value a config write may load.
`define TSB_MAX_TILES       8

`define TSB_TS_WIDTH        16
`define TSB_HINT_WIDTH      16
`define TSB_EPOCH_WIDTH     8
`define TSB_TQ_SLOT_WIDTH   6
`define TSB_CQ_SLOT_WIDTH   4
`define TSB_CHILD_ID_WIDTH  2

`endif

// ==== src/tsb_task_pkg.sv ====
`include "tsb_settings.svh"

package tsb_task_pkg;

   typedef logic [`TSB_TS_WIDTH-1:0]       ts_t;
   typedef logic [`TSB_HINT_WIDTH-1:0]     hint_t;

   // a task as it travels between tiles.
   typedef struct packed {
      ts_t         ts;
      hint_t       hint;
      logic [15:0] arg;
   } task_t;

   typedef logic [`TSB_LOG_SIZE-1:0]       tsb_id_t;
   typedef logic [2:0]                     tile_id_t;

   // response and bookkeeping fields.
   typedef logic [`TSB_EPOCH_WIDTH-1:0]    epoch_t;
   typedef logic [`TSB_TQ_SLOT_WIDTH-1:0]  tq_slot_t;
   typedef logic [`TSB_CQ_SLOT_WIDTH-1:0]  cq_slot_t;
   typedef logic [`TSB_CHILD_ID_WIDTH-1:0] child_id_t;

endpackage

// ==== src/tsb_ctrl_pkg.sv ====
package tsb_ctrl_pkg;

   // configuration register map.
   typedef enum logic [3:0] {
      REG_N_TILES = 4'h1
   } tsb_reg_e;

   // where the word in the enqueue register came from.
   typedef enum logic {
      ENQ_NEW   = 1'b0,
      ENQ_RETRY = 1'b1
   } enq_src_e;

endpackage

// ==== src/tsb_entry_if.sv ====
`timescale 1ns/100ps

interface tsb_entry_if;
   import tsb_task_pkg::*;

   // allocate a new entry at next_id.
   logic      alloc;
   task_t     alloc_task;
   logic      alloc_tied;
   cq_slot_t  alloc_cq_slot;
   child_id_t alloc_child_id;
   tile_id_t  alloc_tile;

   // retry read port, also the retag target.
   tsb_id_t   retry_id;
   logic      retag;
   logic      retag_tied;
   task_t     rd_task;
   tile_id_t  rd_tile;

   logic      free;
   tsb_id_t   free_id;

   tsb_id_t   next_id;
   logic      has_free;

   // response lookup.
   tsb_id_t   resp_id;
   logic      resp_tied;
   tile_id_t  resp_tile;
   cq_slot_t  resp_cq_slot;
   child_id_t resp_child_id;

   modport ctrl (
      output alloc, alloc_task, alloc_tied, alloc_cq_slot, alloc_child_id, alloc_tile,
      output retry_id, retag, retag_tied, free, free_id, resp_id,
      input  next_id, has_free, rd_task, rd_tile,
      input  resp_tied, resp_tile, resp_cq_slot, resp_child_id
   );

   modport store (
      input  alloc, alloc_task, alloc_tied, alloc_cq_slot, alloc_child_id, alloc_tile,
      input  retry_id, retag, retag_tied, free, free_id, resp_id,
      output next_id, has_free, rd_task, rd_tile,
      output resp_tied, resp_tile, resp_cq_slot, resp_child_id
   );

endinterface

// ==== src/tile_mapper.sv ====
`timescale 1ns/100ps
`include "tsb_settings.svh"

module tile_mapper (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   cfg_valid,
   input  tsb_ctrl_pkg::tsb_reg_e cfg_addr,
   input  logic [3:0]             cfg_data,
   input  tsb_task_pkg::hint_t    hint,
   output tsb_task_pkg::tile_id_t tile
);
   import tsb_task_pkg::*;
   import tsb_ctrl_pkg::*;

   logic [3:0]                   n_tiles;
   logic [`TSB_HINT_WIDTH-5:0]   hint_hi;

   // out-of-range counts are ignored.
   always_ff @(posedge clk) begin
      if (!rstn) begin
         n_tiles <= 4'(`TSB_MAX_TILES);
      end else if (cfg_valid && cfg_addr == REG_N_TILES) begin
         if (cfg_data != 4'd0 && cfg_data <= 4'(`TSB_MAX_TILES)) begin
            n_tiles <= cfg_data;
         end
      end
   end

   // low hint bits select within a tile, so they take no part in the hash.
   assign hint_hi = hint[`TSB_HINT_WIDTH-1:4];

   assign tile = tile_id_t'(hint_hi % n_tiles);

endmodule

// ==== src/tsb_entry_store.sv ====
`timescale 1ns/100ps
`include "tsb_settings.svh"

module tsb_entry_store (
   input  logic                  clk,
   input  logic                  rstn,
   tsb_entry_if.store            ent,
   input  tsb_task_pkg::tsb_id_t scan_idx,
   output logic                  scan_valid,
   output tsb_task_pkg::ts_t     scan_ts,
   output logic                  only_untied,
   output logic                  empty
);
   import tsb_task_pkg::*;

   logic [`TSB_SIZE-1:0]  valid;
   logic [`TSB_LOG_SIZE:0] count;

   task_t     ent_task     [`TSB_SIZE];
   tile_id_t  ent_tile     [`TSB_SIZE];
   logic      ent_tied     [`TSB_SIZE];
   cq_slot_t  ent_cq_slot  [`TSB_SIZE];
   child_id_t ent_child_id [`TSB_SIZE];

   // lowest free entry wins.
   always_comb begin
      ent.next_id  = '0;
      ent.has_free = 1'b0;
      for (int i = `TSB_SIZE - 1; i >= 0; i--) begin
         if (!valid[i]) begin
            ent.next_id  = tsb_id_t'(i);
            ent.has_free = 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         valid <= '0;
         count <= '0;
      end else begin
         if (ent.alloc) valid[ent.next_id] <= 1'b1;
         if (ent.free)  valid[ent.free_id] <= 1'b0;
         case ({ent.alloc, ent.free})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (ent.alloc) begin
         ent_task[ent.next_id]     <= ent.alloc_task;
         ent_tile[ent.next_id]     <= ent.alloc_tile;
         ent_tied[ent.next_id]     <= ent.alloc_tied;
         ent_cq_slot[ent.next_id]  <= ent.alloc_cq_slot;
         ent_child_id[ent.next_id] <= ent.alloc_child_id;
      end
      // a retry may change whether the child manager still tracks the task.
      if (ent.retag) ent_tied[ent.retry_id] <= ent.retag_tied;
   end

   assign ent.rd_task       = ent_task[ent.retry_id];
   assign ent.rd_tile       = ent_tile[ent.retry_id];
   assign ent.resp_tied     = ent_tied[ent.resp_id];
   assign ent.resp_tile     = ent_tile[ent.resp_id];
   assign ent.resp_cq_slot  = ent_cq_slot[ent.resp_id];
   assign ent.resp_child_id = ent_child_id[ent.resp_id];

   assign scan_valid = valid[scan_idx];
   assign scan_ts    = ent_task[scan_idx].ts;

   // last few entries are kept for untied tasks.
   assign only_untied = (count > (`TSB_SIZE - 3));
   assign empty       = (valid == '0);

endmodule

// ==== src/lvt_scanner.sv ====
`timescale 1ns/100ps

module lvt_scanner (
   input  logic                  clk,
   input  logic                  rstn,
   output tsb_task_pkg::tsb_id_t scan_idx,
   input  logic                  scan_valid,
   input  tsb_task_pkg::ts_t     scan_ts,
   output tsb_task_pkg::ts_t     lvt
);
   import tsb_task_pkg::*;

   tsb_id_t idx;
   ts_t     rolling;
   ts_t     lvt_q;

   // one entry per cycle; the index wraps on its own.
   always_ff @(posedge clk) begin
      if (!rstn) begin
         idx     <= '0;
         rolling <= '1;
         lvt_q   <= '0;
      end else begin
         idx <= idx + 1'b1;
         if (idx == '0) begin
            // publish the last pass and start over with entry 0.
            lvt_q   <= rolling;
            rolling <= scan_valid ? scan_ts : '1;
         end else if (scan_valid && scan_ts < rolling) begin
            rolling <= scan_ts;
         end
      end
   end

   assign scan_idx = idx;
   assign lvt      = lvt_q;

endmodule

// ==== src/tsb_ctrl.sv ====
`timescale 1ns/100ps

module tsb_ctrl (
   input  logic                    clk,
   input  logic                    rstn,
   input  logic                    s_wvalid,
   output logic                    s_wready,
   input  tsb_task_pkg::task_t     s_wdata,
   input  logic                    s_tied,
   input  tsb_task_pkg::cq_slot_t  s_cq_slot,
   input  tsb_task_pkg::child_id_t s_child_id,
   input  tsb_task_pkg::tile_id_t  s_tile,
   input  logic                    retry_valid,
   output logic                    retry_ready,
   input  tsb_task_pkg::tsb_id_t   retry_id,
   input  logic                    retry_abort,
   input  logic                    retry_tied,
   output logic                    task_enq_valid,
   input  logic                    task_enq_ready,
   output tsb_task_pkg::task_t     task_enq_data,
   output logic                    task_enq_tied,
   output tsb_task_pkg::tile_id_t  task_enq_tile,
   output tsb_task_pkg::tsb_id_t   task_enq_id,
   input  logic                    task_resp_valid,
   output logic                    task_resp_ready,
   input  logic                    task_resp_ack,
   input  tsb_task_pkg::tsb_id_t   task_resp_id,
   input  tsb_task_pkg::epoch_t    task_resp_epoch,
   input  tsb_task_pkg::tq_slot_t  task_resp_tq_slot,
   output logic                    m_resp_valid,
   input  logic                    m_resp_ready,
   output logic                    m_resp_ack,
   output tsb_task_pkg::tsb_id_t   m_resp_id,
   output tsb_task_pkg::epoch_t    m_resp_epoch,
   output tsb_task_pkg::tq_slot_t  m_resp_tq_slot,
   output tsb_task_pkg::tile_id_t  m_resp_tile,
   output tsb_task_pkg::cq_slot_t  m_resp_cq_slot,
   output tsb_task_pkg::child_id_t m_resp_child_id,
   tsb_entry_if.ctrl               ent
);
   import tsb_ctrl_pkg::*;

   logic     enq_open;
   logic     s_fire;
   logic     retry_fire;
   logic     resp_fire;
   logic     resp_free;
   logic     enq_load;
   enq_src_e enq_sel;

   assign enq_open        = !task_enq_valid || task_enq_ready;
   assign s_wready        = enq_open && ent.has_free;
   assign s_fire          = s_wvalid && s_wready;
   assign task_resp_ready = !m_resp_valid;
   assign resp_fire       = task_resp_valid && task_resp_ready;
   assign resp_free       = resp_fire && task_resp_ack;

   // new tasks go first. an abort waits while an ack already frees an entry.
   assign retry_ready = enq_open && !s_fire && !(retry_abort && resp_free);
   assign retry_fire  = retry_valid && retry_ready;
   assign enq_load    = s_fire || (retry_fire && !retry_abort);
   assign enq_sel     = s_fire ? ENQ_NEW : ENQ_RETRY;

   assign ent.alloc          = s_fire;
   assign ent.alloc_task     = s_wdata;
   assign ent.alloc_tied     = s_tied;
   assign ent.alloc_cq_slot  = s_cq_slot;
   assign ent.alloc_child_id = s_child_id;
   assign ent.alloc_tile     = s_tile;
   assign ent.retry_id       = retry_id;
   assign ent.retag          = retry_fire && !retry_abort;
   assign ent.retag_tied     = retry_tied;
   assign ent.free           = resp_free || (retry_fire && retry_abort);
   assign ent.free_id        = resp_free ? task_resp_id : retry_id;
   assign ent.resp_id        = task_resp_id;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         task_enq_valid <= 1'b0;
      end else if (enq_load) begin
         task_enq_valid <= 1'b1;
      end else if (task_enq_ready) begin
         task_enq_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (enq_load) begin
         case (enq_sel)
            ENQ_NEW: begin
               task_enq_data <= s_wdata;
               task_enq_tied <= s_tied;
               task_enq_tile <= s_tile;
               task_enq_id   <= ent.next_id;
            end
            ENQ_RETRY: begin
               task_enq_data <= ent.rd_task;
               task_enq_tied <= retry_tied;
               task_enq_tile <= ent.rd_tile;
               task_enq_id   <= retry_id;
            end
         endcase
      end
   end

   // untied tasks are not reported back.
   always_ff @(posedge clk) begin
      if (!rstn) begin
         m_resp_valid <= 1'b0;
      end else if (resp_fire && ent.resp_tied) begin
         m_resp_valid <= 1'b1;
      end else if (m_resp_ready) begin
         m_resp_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (resp_fire && ent.resp_tied) begin
         m_resp_ack      <= task_resp_ack;
         m_resp_id       <= task_resp_id;
         m_resp_epoch    <= task_resp_epoch;
         m_resp_tq_slot  <= task_resp_tq_slot;
         m_resp_tile     <= ent.resp_tile;
         m_resp_cq_slot  <= ent.resp_cq_slot;
         m_resp_child_id <= ent.resp_child_id;
      end
   end

endmodule

// ==== src/tsb_top.sv ====
`timescale 1ns/100ps

module tsb_top (
   input  logic                    clk,
   input  logic                    rstn,
   input  logic                    s_wvalid,
   output logic                    s_wready,
   input  tsb_task_pkg::task_t     s_wdata,
   input  logic                    s_tied,
   input  tsb_task_pkg::cq_slot_t  s_cq_slot,
   input  tsb_task_pkg::child_id_t s_child_id,
   input  logic                    retry_valid,
   output logic                    retry_ready,
   input  tsb_task_pkg::tsb_id_t   retry_id,
   input  logic                    retry_abort,
   input  logic                    retry_tied,
   output logic                    task_enq_valid,
   input  logic                    task_enq_ready,
   output tsb_task_pkg::task_t     task_enq_data,
   output logic                    task_enq_tied,
   output tsb_task_pkg::tile_id_t  task_enq_tile,
   output tsb_task_pkg::tsb_id_t   task_enq_id,
   input  logic                    task_resp_valid,
   output logic                    task_resp_ready,
   input  logic                    task_resp_ack,
   input  tsb_task_pkg::tsb_id_t   task_resp_id,
   input  tsb_task_pkg::epoch_t    task_resp_epoch,
   input  tsb_task_pkg::tq_slot_t  task_resp_tq_slot,
   output logic                    m_resp_valid,
   input  logic                    m_resp_ready,
   output logic                    m_resp_ack,
   output tsb_task_pkg::tsb_id_t   m_resp_id,
   output tsb_task_pkg::epoch_t    m_resp_epoch,
   output tsb_task_pkg::tq_slot_t  m_resp_tq_slot,
   output tsb_task_pkg::tile_id_t  m_resp_tile,
   output tsb_task_pkg::cq_slot_t  m_resp_cq_slot,
   output tsb_task_pkg::child_id_t m_resp_child_id,
   input  logic                    cfg_valid,
   input  logic [3:0]              cfg_addr,
   input  logic [3:0]              cfg_data,
   output logic                    only_untied,
   output logic                    empty,
   output tsb_task_pkg::ts_t       lvt
);
   import tsb_task_pkg::*;
   import tsb_ctrl_pkg::*;

   tsb_reg_e cfg_reg;
   tile_id_t tile;
   tsb_id_t  scan_idx;
   logic     scan_valid;
   ts_t      scan_ts;

   assign cfg_reg = tsb_reg_e'(cfg_addr);

   tsb_entry_if ent ();

   tile_mapper u_mapper (
      .clk, .rstn, .cfg_valid, .cfg_addr(cfg_reg), .cfg_data,
      .hint(s_wdata.hint), .tile
   );

   tsb_entry_store u_store (
      .clk, .rstn, .ent(ent.store),
      .scan_idx, .scan_valid, .scan_ts, .only_untied, .empty
   );

   lvt_scanner u_lvt (
      .clk, .rstn, .scan_idx, .scan_valid, .scan_ts, .lvt
   );

   // the mapper's tile goes with every new task.
   tsb_ctrl u_ctrl (
      .*,
      .s_tile(tile),
      .ent(ent.ctrl)
   );

endmodule

// ==== tests/tsb_tb.sv ====
`timescale 1ns/100ps
`include "tsb_settings.svh"

module tsb_tb;
   import tsb_task_pkg::*;
   import tsb_ctrl_pkg::*;

   logic      clk;
   logic      rstn;
   logic      s_wvalid;
   logic      s_wready;
   task_t     s_wdata;
   logic      s_tied;
   cq_slot_t  s_cq_slot;
   child_id_t s_child_id;
   logic      retry_valid;
   logic      retry_ready;
   tsb_id_t   retry_id;
   logic      retry_abort;
   logic      retry_tied;
   logic      task_enq_valid;
   logic      task_enq_ready;
   task_t     task_enq_data;
   logic      task_enq_tied;
   tile_id_t  task_enq_tile;
   tsb_id_t   task_enq_id;
   logic      task_resp_valid;
   logic      task_resp_ready;
   logic      task_resp_ack;
   tsb_id_t   task_resp_id;
   epoch_t    task_resp_epoch;
   tq_slot_t  task_resp_tq_slot;
   logic      m_resp_valid;
   logic      m_resp_ready;
   logic      m_resp_ack;
   tsb_id_t   m_resp_id;
   epoch_t    m_resp_epoch;
   tq_slot_t  m_resp_tq_slot;
   tile_id_t  m_resp_tile;
   cq_slot_t  m_resp_cq_slot;
   child_id_t m_resp_child_id;
   logic      cfg_valid;
   logic [3:0] cfg_addr;
   logic [3:0] cfg_data;
   logic      only_untied;
   logic      empty;
   ts_t       lvt;

   // reference model of the buffer entries.
   logic [`TSB_SIZE-1:0] mdl_valid;
   task_t     mdl_task  [`TSB_SIZE];
   tile_id_t  mdl_tile  [`TSB_SIZE];
   logic      mdl_tied  [`TSB_SIZE];
   cq_slot_t  mdl_cq    [`TSB_SIZE];
   child_id_t mdl_child [`TSB_SIZE];
   int        mdl_count;
   int        n_tiles_m;
   ts_t       exp_lvt;

   logic        enq_chk;
   logic        exp_new;
   logic [51:0] exp_enq;
   tsb_id_t     exp_id;
   cq_slot_t    exp_cq;
   child_id_t   exp_child;
   logic        m_chk;
   logic        m_tied_exp;
   logic [26:0] exp_m;
   logic        enq_hold;
   logic [54:0] prev_enq;
   logic        m_hold;
   logic [26:0] prev_m;
   logic        rst_chk;
   logic        lvt_chk;

   logic [51:0] enq_word;
   logic [26:0] m_word;
   logic        s_fire;
   logic        retry_fire;
   logic        resp_fire;

   int    new_pct;
   int    retry_pct;
   int    resp_pct;
   int    ack_pct;
   int    rdy_pct;
   int    mismatches;
   int    other_errors;
   int    cycles;
   string test_name;
   int    tile_counts[3] = '{3, 5, 8};

   tsb_top DUT (.*);

   always #4 clk = ~clk;

   assign enq_word   = {task_enq_data, task_enq_tied, task_enq_tile};
   assign m_word     = {m_resp_ack, m_resp_id, m_resp_epoch, m_resp_tq_slot,
                        m_resp_tile, m_resp_cq_slot, m_resp_child_id};
   assign s_fire     = s_wvalid && s_wready;
   assign retry_fire = retry_valid && retry_ready;
   assign resp_fire  = task_resp_valid && task_resp_ready;

   function automatic tile_id_t map_tile(hint_t hint);
      return tile_id_t'((hint >> 4) % n_tiles_m);
   endfunction

   always_comb begin
      exp_lvt = '1;
      for (int i = 0; i < `TSB_SIZE; i++) begin
         if (mdl_valid[i] && mdl_task[i].ts < exp_lvt) exp_lvt = mdl_task[i].ts;
      end
   end

   task automatic report_mismatch(string check, logic [63:0] expected, logic [63:0] actual);
      mismatches++;
      $display("Mismatch %s %s: expected %0h actual %0h", test_name, check, expected, actual);
   endtask

   task automatic report_error(string msg);
      other_errors++;
      $display("Error in %s: %s", test_name, msg);
   endtask

   task automatic print_summary();
      $display("checks done: %0d mismatches, %0d other errors", mismatches, other_errors);
   endtask

   always @(posedge clk) begin
      if (!rstn) begin
         mdl_valid <= '0;
         mdl_count <= 0;
         n_tiles_m <= `TSB_MAX_TILES;
         enq_chk   <= 1'b0;
         m_chk     <= 1'b0;
         enq_hold  <= 1'b0;
         m_hold    <= 1'b0;
      end else begin
         enq_chk <= s_fire || (retry_fire && !retry_abort);
         if (s_fire) begin
            exp_new   <= 1'b1;
            exp_enq   <= {s_wdata, s_tied, map_tile(s_wdata.hint)};
            exp_cq    <= s_cq_slot;
            exp_child <= s_child_id;
         end else if (retry_fire && !retry_abort) begin
            exp_new <= 1'b0;
            exp_enq <= {mdl_task[retry_id], retry_tied, mdl_tile[retry_id]};
            exp_id  <= retry_id;
            mdl_tied[retry_id] <= retry_tied;
         end
         // a new entry's id is first seen on task_enq.
         if (enq_chk && exp_new) begin
            mdl_valid[task_enq_id] <= 1'b1;
            {mdl_task[task_enq_id], mdl_tied[task_enq_id], mdl_tile[task_enq_id]} <= exp_enq;
            mdl_cq[task_enq_id]    <= exp_cq;
            mdl_child[task_enq_id] <= exp_child;
         end
         m_chk <= resp_fire;
         if (resp_fire) begin
            m_tied_exp <= mdl_tied[task_resp_id];
            exp_m <= {task_resp_ack, task_resp_id, task_resp_epoch, task_resp_tq_slot,
                      mdl_tile[task_resp_id], mdl_cq[task_resp_id], mdl_child[task_resp_id]};
         end
         if (resp_fire && task_resp_ack) mdl_valid[task_resp_id] <= 1'b0;
         if (retry_fire && retry_abort) mdl_valid[retry_id] <= 1'b0;
         mdl_count <= mdl_count + int'(s_fire) - int'(resp_fire && task_resp_ack)
                      - int'(retry_fire && retry_abort);
         if (cfg_valid && cfg_addr == REG_N_TILES) n_tiles_m <= int'(cfg_data);
         enq_hold <= task_enq_valid && !task_enq_ready;
         prev_enq <= {enq_word, task_enq_id};
         m_hold   <= m_resp_valid && !m_resp_ready;
         prev_m   <= m_word;
      end
   end

   reset_check: assert property (@(posedge clk)
      rst_chk |-> !task_enq_valid && !m_resp_valid && empty && lvt == '0)
      else report_mismatch("reset", 64'({3'b001, 16'h0}),
                           64'({task_enq_valid, m_resp_valid, empty, lvt}));
   enq_word_check: assert property (@(posedge clk)
      rstn && enq_chk |-> task_enq_valid && enq_word == exp_enq)
      else report_mismatch("task_enq", 64'(exp_enq), 64'(enq_word));
   new_id_check: assert property (@(posedge clk)
      rstn && enq_chk && exp_new |-> !mdl_valid[task_enq_id])
      else report_error($sformatf("id %0d given to a new task while still live", task_enq_id));
   retry_id_check: assert property (@(posedge clk)
      rstn && enq_chk && !exp_new |-> task_enq_id == exp_id)
      else report_mismatch("retry_id", 64'(exp_id), 64'(task_enq_id));
   tied_resp_check: assert property (@(posedge clk)
      rstn && m_chk && m_tied_exp |-> m_resp_valid && m_word == exp_m)
      else report_mismatch("m_resp", 64'(exp_m), 64'(m_word));
   untied_resp_check: assert property (@(posedge clk)
      rstn && m_chk && !m_tied_exp |-> !m_resp_valid)
      else report_error("m_resp raised for an untied task");
   full_check: assert property (@(posedge clk)
      rstn && mdl_count == `TSB_SIZE |-> !s_wready)
      else report_error("s_wready high while every entry is held");
   only_untied_check: assert property (@(posedge clk)
      rstn |-> only_untied == (mdl_count > `TSB_SIZE - 3))
      else report_mismatch("only_untied", 64'(mdl_count > `TSB_SIZE - 3), 64'(only_untied));
   empty_check: assert property (@(posedge clk)
      rstn |-> empty == (mdl_count == 0))
      else report_mismatch("empty", 64'(mdl_count == 0), 64'(empty));
   lvt_check: assert property (@(posedge clk)
      lvt_chk |-> lvt == exp_lvt)
      else report_mismatch("lvt", 64'(exp_lvt), 64'(lvt));
   enq_stall_check: assert property (@(posedge clk)
      rstn && enq_hold |-> task_enq_valid && {enq_word, task_enq_id} == prev_enq)
      else report_mismatch("task_enq stall", 64'(prev_enq), 64'({enq_word, task_enq_id}));
   m_stall_check: assert property (@(posedge clk)
      rstn && m_hold |-> m_resp_valid && m_word == prev_m)
      else report_mismatch("m_resp stall", 64'(prev_m), 64'(m_word));

   // valid is raised only by a load and kept only by a stall.
   enq_valid_check: assert property (@(posedge clk)
      rstn |-> task_enq_valid == (enq_chk || enq_hold))
      else report_mismatch("task_enq_valid", 64'(enq_chk || enq_hold), 64'(task_enq_valid));
   m_valid_check: assert property (@(posedge clk)
      rstn |-> m_resp_valid == ((m_chk && m_tied_exp) || m_hold))
      else report_mismatch("m_resp_valid", 64'((m_chk && m_tied_exp) || m_hold),
                           64'(m_resp_valid));
   input_stall_check: assert property (@(posedge clk)
      rstn && task_enq_valid && !task_enq_ready |-> !s_wready && !retry_ready)
      else report_error("an input stream is ready while task_enq is stalled");
   s_wready_check: assert property (@(posedge clk)
      rstn && (!task_enq_valid || task_enq_ready) && mdl_count < `TSB_SIZE |-> s_wready)
      else report_error("s_wready low with the enqueue slot open and an entry free");
   retry_ready_check: assert property (@(posedge clk)
      rstn && (!task_enq_valid || task_enq_ready) && !s_fire && !retry_abort |-> retry_ready)
      else report_error("retry_ready low with the enqueue slot open and no new task");
   retry_order_check: assert property (@(posedge clk)
      rstn && s_fire |-> !retry_ready)
      else report_error("retry_ready high in a cycle that takes a new task");
   resp_ready_check: assert property (@(posedge clk)
      rstn |-> task_resp_ready == !m_resp_valid)
      else report_mismatch("task_resp_ready", 64'(!m_resp_valid), 64'(task_resp_ready));

   // a live id from the model, other than excl, or -1.
   function automatic int pick_live(int excl);
      int start;
      int idx;
      start = int'($urandom % `TSB_SIZE);
      for (int i = 0; i < `TSB_SIZE; i++) begin
         idx = (start + i) % `TSB_SIZE;
         if (mdl_valid[idx] && idx != excl) return idx;
      end
      return -1;
   endfunction

   task automatic drive_inputs();
      int k;
      int j;
      k = pick_live(-1);
      s_wvalid          = ($urandom % 100) < new_pct;
      s_wdata           = {ts_t'($urandom), hint_t'($urandom), 16'($urandom)};
      s_tied            = 1'($urandom);
      s_cq_slot         = cq_slot_t'($urandom);
      s_child_id        = child_id_t'($urandom);
      retry_valid       = (k >= 0) && (($urandom % 100) < retry_pct);
      retry_id          = tsb_id_t'(k);
      retry_abort       = 1'($urandom);
      retry_tied        = 1'($urandom);
      // a response never targets the entry being retried.
      j = pick_live(retry_valid ? k : -1);
      task_resp_valid   = (j >= 0) && (($urandom % 100) < resp_pct);
      task_resp_id      = tsb_id_t'(j);
      task_resp_ack     = ($urandom % 100) < ack_pct;
      task_resp_epoch   = epoch_t'($urandom);
      task_resp_tq_slot = tq_slot_t'($urandom);
      task_enq_ready    = ($urandom % 100) < rdy_pct;
      m_resp_ready      = ($urandom % 100) < rdy_pct;
   endtask

   task automatic run_phase(int n, int p_new, int p_retry, int p_resp, int p_ack, int p_rdy);
      new_pct   = p_new;
      retry_pct = p_retry;
      resp_pct  = p_resp;
      ack_pct   = p_ack;
      rdy_pct   = p_rdy;
      repeat (n) begin
         @(negedge clk);
         drive_inputs();
      end
   endtask

   task automatic drain_entries();
      run_phase(0, 0, 0, 100, 100, 100);
      while (mdl_count != 0) begin
         @(negedge clk);
         drive_inputs();
      end
   endtask

   // the scanner needs up to two passes once entries stop changing.
   task automatic settle_and_check_lvt();
      @(negedge clk);
      s_wvalid        = 1'b0;
      retry_valid     = 1'b0;
      task_resp_valid = 1'b0;
      task_enq_ready  = 1'b1;
      m_resp_ready    = 1'b1;
      repeat (20) @(negedge clk);
      lvt_chk = 1'b1;
      @(negedge clk);
      lvt_chk = 1'b0;
   endtask

   task automatic write_tile_count(logic [3:0] n);
      @(negedge clk);
      s_wvalid        = 1'b0;
      retry_valid     = 1'b0;
      task_resp_valid = 1'b0;
      cfg_valid       = 1'b1;
      cfg_addr        = REG_N_TILES;
      cfg_data        = n;
      @(negedge clk);
      cfg_valid = 1'b0;
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycles >= 3000) begin
         report_error("timeout, the run did not finish within 3000 cycles");
         print_summary();
         $display("Some tests failed");
         $finish;
      end
   end

   initial begin
      void'($urandom(32'hb2f));
      clk = 1'b0;
      rstn = 1'b0;
      {s_wvalid, s_tied, s_wdata, s_cq_slot, s_child_id} = '0;
      {retry_valid, retry_id, retry_abort, retry_tied} = '0;
      {task_resp_valid, task_resp_ack, task_resp_id, task_resp_epoch, task_resp_tq_slot} = '0;
      task_enq_ready = 1'b1;
      m_resp_ready = 1'b1;
      {cfg_valid, cfg_addr, cfg_data} = '0;
      {rst_chk, lvt_chk} = '0;
      mismatches = 0;
      other_errors = 0;
      cycles = 0;
      test_name = "reset";
      repeat (3) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
      rst_chk = 1'b1;
      @(negedge clk);
      rst_chk = 1'b0;

      test_name = "tile_map";
      run_phase(60, 60, 0, 40, 100, 100);
      drain_entries();
      settle_and_check_lvt();
      foreach (tile_counts[i]) begin
         write_tile_count(4'(tile_counts[i]));
         run_phase(60, 60, 0, 40, 100, 100);
         drain_entries();
         settle_and_check_lvt();
      end

      test_name = "retry";
      run_phase(300, 30, 40, 40, 50, 100);
      settle_and_check_lvt();
      drain_entries();
      settle_and_check_lvt();

      // new tasks keep coming while the buffer is full.
      test_name = "fill";
      run_phase(30, 100, 0, 0, 100, 100);
      settle_and_check_lvt();
      drain_entries();
      settle_and_check_lvt();

      test_name = "backpressure";
      run_phase(400, 40, 30, 40, 60, 50);
      settle_and_check_lvt();
      drain_entries();
      settle_and_check_lvt();

      print_summary();
      if (mismatches == 0 && other_errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// ==== tb.f ====
+incdir+include
src/tsb_task_pkg.sv
src/tsb_ctrl_pkg.sv
src/tsb_entry_if.sv
src/tile_mapper.sv
src/tsb_entry_store.sv
src/lvt_scanner.sv
src/tsb_ctrl.sv
src/tsb_top.sv
tests/tsb_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and scan the log for failures.
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tsb_tb -f tb.f -o tsb_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/tsb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
   exit 1
fi
exit 0
